//--- list.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/hazard_unit.sv
verilog/cpu_top.sv
tb/tb_cpu_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f list.f --top-module tb_cpu_top -o sim_cpu

# the simulator exits nonzero on $fatal, so keep its output and decide by the pass line
out=$(./obj_dir/sim_cpu || true)
echo "$out"
echo "$out" | grep -q "Test completed successfully"

//--- tb/cpu_golden.txt
// program words from 0x00, 16 initial data words from 0x40, store count and halt pc at 0x50
// expected stores from 0x52 as address/data pairs in program order
@00
00C00093 FFB00113 002081B3 00302023  // addi x1, addi x2, add x3, sw x3
40208233 0020F2B3 0020E333 0020C3B3  // sub, and, or, xor
00112433 0020A4B3 00402223 00502423  // slt x8, slt x9, sw x4, sw x5
00602623 00702823 00802A23 00902C23  // sw x6 .. sw x9
12345537 06300013 000505B3 00B02E23  // lui x10, addi x0, add x11, sw x11
03002603 001606B3 02D02023 00108663  // lw x12, add x13 on load-use, sw x13, beq taken
02102E23 02202E23 00209663 02102E23  // skipped, skipped, bne taken, skipped
02202E23 00C0076F 02102E23 02202E23  // skipped, jal x14, skipped, skipped
02E02223 03402783 02F02423 0000006F  // sw x14, lw x15, sw x15 on load-use, self-loop
@40
A0000000 A0000004 A0000008 A000000C
A0000010 A0000014 A0000018 A000001C
A0000020 A0000024 A0000028 A000002C
00001000 CAFE0042 A0000038 A000003C
@50
0000000B 0000008C
@52
00000000 00000007 00000004 00000011  // add, sub
00000008 00000008 0000000C FFFFFFFF  // and, or
00000010 FFFFFFF7 00000014 00000001  // xor, slt true
00000018 00000000 0000001C 12345000  // slt false, lui through x0 add
00000020 0000100C 00000024 00000078  // load-use sum, jal link
00000028 CAFE0042                    // loaded word as store data

//--- tb/tb_cpu_top.sv
`default_nettype none

`include "rv_defs.svh"

module tb_cpu_top;
  timeunit 1ns;
  timeprecision 100ps;

  // word indices in the golden file
  localparam logic [6:0] DATA_BASE = 7'h40;
  localparam logic [6:0] COUNT_IDX = 7'h50;
  localparam logic [6:0] HALT_IDX  = 7'h51;
  localparam logic [6:0] REC_BASE  = 7'h52;

  localparam int RESET_CYCLES  = 16;
  localparam int STORE_TIMEOUT = 200;
  localparam int HALT_TIMEOUT  = 100;
  localparam int DRAIN_CYCLES  = 12;

  logic                clk;
  logic                reset_i;
  logic [`RV_XLEN-1:0] imem_data_i;
  logic [`RV_XLEN-1:0] dmem_rdata_i;
  logic [`RV_XLEN-1:0] imem_addr_o;
  pipe_pkg::dmem_req_t dmem_req_o;

  logic [31:0]         golden [0:127];
  logic [31:0]         dmem [0:15];
  pipe_pkg::dmem_req_t wr_req;

  cpu_top dut_i (
     .clk          (clk         )
    ,.reset_i      (reset_i     )
    ,.imem_data_i  (imem_data_i )
    ,.dmem_rdata_i (dmem_rdata_i)
    ,.imem_addr_o  (imem_addr_o )
    ,.dmem_req_o   (dmem_req_o  )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // words past the final self-loop read as nop
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr > golden[HALT_IDX]) begin
      return `RV_NOP;
    end
    return golden[{1'b0, addr[7:2]}];
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_fetch_addr(input logic [`RV_XLEN-1:0] exp,
                                  input logic [`RV_XLEN-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] t=%0.1f ns imem_addr_o expected %h got %h", $realtime, exp, act);
      abort_run();
    end
  endtask

  task automatic check_we(input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] t=%0.1f ns dmem_req_o.we expected %b got %b", $realtime, exp, act);
      abort_run();
    end
  endtask

  task automatic check_store(input int num, input pipe_pkg::dmem_req_t exp,
                             input pipe_pkg::dmem_req_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0.1f ns dmem_req_o store %0d expected %h/%h got %h/%h",
               $realtime, num, exp.addr, exp.wdata, act.addr, act.wdata);
      abort_run();
    end
  endtask

  // instruction and data memories answer within the cycle
  initial begin : mem_model
    int i;
    $readmemh("tb/cpu_golden.txt", golden);
    for (i = 0; i < 16; i++) begin
      dmem[i] = golden[DATA_BASE + 7'(i)];
    end
    imem_data_i  = `RV_NOP;
    dmem_rdata_i = '0;
    forever begin
      // request is stable mid-cycle, the write lands on the next rising edge
      @(negedge clk);
      wr_req = dmem_req_o;
      @(posedge clk);
      if (wr_req.we === 1'b1) begin
        dmem[wr_req.addr[5:2]] = wr_req.wdata;
      end
      #0.5;
      imem_data_i  = fetch_word(imem_addr_o);
      dmem_rdata_i = dmem[dmem_req_o.addr[5:2]];
    end
  end

  initial begin : main
    int                  store_count;
    int                  rec;
    int                  waited;
    logic                seen;
    logic [6:0]          rec_idx;
    pipe_pkg::dmem_req_t exp_req;

    reset_i = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #0.5;
    reset_i = 1'b0;

    // pc still at boot and nothing in flight
    @(negedge clk);
    check_fetch_addr(`RV_BOOT_ADDR, imem_addr_o);
    check_we(1'b0, dmem_req_o.we);

    store_count = int'(golden[COUNT_IDX]);
    for (rec = 0; rec < store_count; rec++) begin
      rec_idx       = REC_BASE + 7'(2 * rec);
      exp_req.addr  = golden[rec_idx];
      exp_req.wdata = golden[rec_idx + 7'd1];
      exp_req.we    = 1'b1;
      seen          = 1'b0;
      waited        = 0;
      while (!seen) begin
        @(negedge clk);
        if (dmem_req_o.we === 1'b1) begin
          seen = 1'b1;
        end else begin
          waited++;
          if (waited >= STORE_TIMEOUT) begin
            $display("[ERROR] t=%0.1f ns store %0d never reached dmem_req_o in %0d cycles",
                     $realtime, rec, STORE_TIMEOUT);
            abort_run();
          end
        end
      end
      check_store(rec, exp_req, dmem_req_o);
    end

    // no further write may show up once the program spins
    waited = 0;
    while (imem_addr_o !== golden[HALT_IDX]) begin
      @(negedge clk);
      check_we(1'b0, dmem_req_o.we);
      waited++;
      if (waited >= HALT_TIMEOUT) begin
        $display("[ERROR] t=%0.1f ns fetch never reached the final self-loop at %h",
                 $realtime, golden[HALT_IDX]);
        abort_run();
      end
    end
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      check_we(1'b0, dmem_req_o.we);
    end

    if (store_count > 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("[ERROR] t=%0.1f ns golden file holds no store records", $realtime);
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`default_nettype none

`include "rv_defs.svh"

module cpu_top (
  input  logic                clk,
  input  logic                reset_i,
  input  logic [`RV_XLEN-1:0] imem_data_i,
  input  logic [`RV_XLEN-1:0] dmem_rdata_i,
  output logic [`RV_XLEN-1:0] imem_addr_o,
  output pipe_pkg::dmem_req_t dmem_req_o
);

  pipe_pkg::if_id_t       if_id;
  pipe_pkg::id_ex_t       id_ex;
  pipe_pkg::ex_mem_t      ex_mem;
  pipe_pkg::mem_wb_t      mem_wb;
  pipe_pkg::hazard_ctrl_t hz;
  logic [4:0]             id_rs1;
  logic [4:0]             id_rs2;
  logic                   redirect_valid;
  logic [`RV_XLEN-1:0]    redirect_pc;

  fetch_stage fetch (
     .clk              (clk            )
    ,.reset_i          (reset_i        )
    ,.imem_data_i      (imem_data_i    )
    ,.redirect_valid_i (redirect_valid )
    ,.redirect_pc_i    (redirect_pc    )
    ,.hz_i             (hz             )
    ,.imem_addr_o      (imem_addr_o    )
    ,.if_id_o          (if_id          )
  );

  decode_stage decode (
     .clk              (clk            )
    ,.reset_i          (reset_i        )
    ,.if_id_i          (if_id          )
    ,.wb_i             (mem_wb         )
    ,.hz_i             (hz             )
    ,.id_ex_o          (id_ex          )
    ,.rs1_o            (id_rs1         )
    ,.rs2_o            (id_rs2         )
  );

  // ex_mem loops back for memory-stage forwarding
  execute_stage execute (
     .clk              (clk            )
    ,.reset_i          (reset_i        )
    ,.id_ex_i          (id_ex          )
    ,.mem_fwd_i        (ex_mem         )
    ,.wb_i             (mem_wb         )
    ,.hz_i             (hz             )
    ,.ex_mem_o         (ex_mem         )
    ,.redirect_valid_o (redirect_valid )
    ,.redirect_pc_o    (redirect_pc    )
  );

  mem_stage memory (
     .clk              (clk            )
    ,.reset_i          (reset_i        )
    ,.ex_mem_i         (ex_mem         )
    ,.dmem_rdata_i     (dmem_rdata_i   )
    ,.dmem_req_o       (dmem_req_o     )
    ,.wb_o             (mem_wb         )
  );

  hazard_unit hazard (
     .id_rs1_i         (id_rs1         )
    ,.id_rs2_i         (id_rs2         )
    ,.id_ex_i          (id_ex          )
    ,.ex_mem_i         (ex_mem         )
    ,.wb_i             (mem_wb         )
    ,.redirect_valid_i (redirect_valid )
    ,.hz_o             (hz             )
  );

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
`default_nettype none

module hazard_unit (
  input  logic                   [4:0] id_rs1_i,
  input  logic                   [4:0] id_rs2_i,
  input  pipe_pkg::id_ex_t       id_ex_i,
  input  pipe_pkg::ex_mem_t      ex_mem_i,
  input  pipe_pkg::mem_wb_t      wb_i,
  input  logic                   redirect_valid_i,
  output pipe_pkg::hazard_ctrl_t hz_o
);

  logic load_use;

  // memory stage is the younger result, so it wins over writeback
  function automatic pipe_pkg::fwd_sel_e fwd_pick(input logic [4:0] rs,
                                                  input logic [4:0] mem_rd,
                                                  input logic       mem_we,
                                                  input logic [4:0] wb_rd,
                                                  input logic       wb_we);
    if (rs == 5'd0) begin
      return pipe_pkg::FWD_NONE;
    end else if (mem_we && mem_rd == rs) begin
      return pipe_pkg::FWD_FROM_MEM;
    end else if (wb_we && wb_rd == rs) begin
      return pipe_pkg::FWD_FROM_WB;
    end
    return pipe_pkg::FWD_NONE;
  endfunction

  // load in execute feeding the instruction in decode
  assign load_use = id_ex_i.mem_read && (id_ex_i.rd != 5'd0) &&
                    ((id_ex_i.rd == id_rs1_i) || (id_ex_i.rd == id_rs2_i));

  assign hz_o.fwd_a = fwd_pick(id_ex_i.rs1, ex_mem_i.rd, ex_mem_i.reg_write,
                               wb_i.rd, wb_i.reg_write);
  assign hz_o.fwd_b = fwd_pick(id_ex_i.rs2, ex_mem_i.rd, ex_mem_i.reg_write,
                               wb_i.rd, wb_i.reg_write);
  assign hz_o.stall = load_use;
  assign hz_o.flush = redirect_valid_i;

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`default_nettype none

`include "rv_defs.svh"

module mem_stage (
  input  logic                 clk,
  input  logic                 reset_i,
  input  pipe_pkg::ex_mem_t    ex_mem_i,
  input  logic [`RV_XLEN-1:0]  dmem_rdata_i,
  output pipe_pkg::dmem_req_t  dmem_req_o,
  output pipe_pkg::mem_wb_t    wb_o
);

  logic [`RV_XLEN-1:0] wdata;

  // word access only, memory answers in the same cycle
  assign dmem_req_o.addr  = ex_mem_i.alu_res;
  assign dmem_req_o.wdata = ex_mem_i.store_data;
  assign dmem_req_o.we    = ex_mem_i.mem_write;

  // writeback value select
  always_comb begin
    if (ex_mem_i.mem_read) begin
      wdata = dmem_rdata_i;
    end else if (ex_mem_i.jump) begin
      wdata = ex_mem_i.link_pc;
    end else begin
      wdata = ex_mem_i.alu_res;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_o.reg_write <= 1'b0;
    end else begin
      wb_o.reg_write <= ex_mem_i.reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_o.wdata <= wdata;
    wb_o.rd    <= ex_mem_i.rd;
  end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

`include "rv_defs.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   reset_i,
  input  pipe_pkg::id_ex_t       id_ex_i,
  input  pipe_pkg::ex_mem_t      mem_fwd_i,
  input  pipe_pkg::mem_wb_t      wb_i,
  input  pipe_pkg::hazard_ctrl_t hz_i,
  output pipe_pkg::ex_mem_t      ex_mem_o,
  output logic                   redirect_valid_o,
  output logic [`RV_XLEN-1:0]    redirect_pc_o
);

  logic [`RV_XLEN-1:0] mem_val;
  logic [`RV_XLEN-1:0] rs1_fwd;
  logic [`RV_XLEN-1:0] rs2_fwd;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_res;
  logic                equal;

  function automatic logic [`RV_XLEN-1:0] fwd_mux(input pipe_pkg::fwd_sel_e sel,
                                                  input logic [`RV_XLEN-1:0] reg_val,
                                                  input logic [`RV_XLEN-1:0] from_mem,
                                                  input logic [`RV_XLEN-1:0] from_wb);
    case (sel)
      pipe_pkg::FWD_FROM_MEM: return from_mem;
      pipe_pkg::FWD_FROM_WB:  return from_wb;
      default:                return reg_val;
    endcase
  endfunction

  // a jal in memory forwards its link value
  assign mem_val = mem_fwd_i.jump ? mem_fwd_i.link_pc : mem_fwd_i.alu_res;

  assign rs1_fwd = fwd_mux(hz_i.fwd_a, id_ex_i.rs1_val, mem_val, wb_i.wdata);
  assign rs2_fwd = fwd_mux(hz_i.fwd_b, id_ex_i.rs2_val, mem_val, wb_i.wdata);
  assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;

  always_comb begin
    case (id_ex_i.alu_op)
      rv_isa_pkg::ALU_SUB:    alu_res = rs1_fwd - op_b;
      rv_isa_pkg::ALU_AND:    alu_res = rs1_fwd & op_b;
      rv_isa_pkg::ALU_OR:     alu_res = rs1_fwd | op_b;
      rv_isa_pkg::ALU_XOR:    alu_res = rs1_fwd ^ op_b;
      rv_isa_pkg::ALU_SLT:    alu_res = {31'b0, $signed(rs1_fwd) < $signed(op_b)};
      rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
      default:                alu_res = rs1_fwd + op_b;
    endcase
  end

  // beq/bne compare, target is pc + imm for both branch and jal
  assign equal            = (rs1_fwd == rs2_fwd);
  assign redirect_valid_o = id_ex_i.valid &&
                            (id_ex_i.jump || (id_ex_i.branch && (equal ^ id_ex_i.branch_ne)));
  assign redirect_pc_o    = id_ex_i.pc + id_ex_i.imm;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_mem_o.reg_write <= 1'b0;
      ex_mem_o.mem_read  <= 1'b0;
      ex_mem_o.mem_write <= 1'b0;
      ex_mem_o.jump      <= 1'b0;
    end else begin
      ex_mem_o.reg_write <= id_ex_i.reg_write;
      ex_mem_o.mem_read  <= id_ex_i.mem_read;
      ex_mem_o.mem_write <= id_ex_i.mem_write;
      ex_mem_o.jump      <= id_ex_i.jump;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem_o.alu_res    <= alu_res;
    ex_mem_o.store_data <= rs2_fwd;
    ex_mem_o.rd         <= id_ex_i.rd;
    ex_mem_o.link_pc    <= id_ex_i.pc + 32'd4;
  end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none

`include "rv_defs.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   reset_i,
  input  pipe_pkg::if_id_t       if_id_i,
  input  pipe_pkg::mem_wb_t      wb_i,
  input  pipe_pkg::hazard_ctrl_t hz_i,
  output pipe_pkg::id_ex_t       id_ex_o,
  output logic [4:0]             rs1_o,
  output logic [4:0]             rs2_o
);

  logic [`RV_XLEN-1:0] instr;
  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [4:0]          rd;
  logic                uses_rs1;
  logic                uses_rs2;
  logic [`RV_XLEN-1:0] imm;
  rv_isa_pkg::alu_op_e alu_op;
  logic                use_imm;
  logic                reg_write;
  logic                mem_read;
  logic                mem_write;
  logic                branch;
  logic                jump;
  logic [`RV_XLEN-1:0] rs1_val;
  logic [`RV_XLEN-1:0] rs2_val;
  logic [`RV_XLEN-1:0] regs [`RV_REGS];

  assign instr  = if_id_i.instr;
  assign opcode = rv_isa_pkg::opcode_e'(instr[`RV_OPCODE]);
  assign funct3 = instr[`RV_FUNCT3];
  assign funct7 = instr[`RV_FUNCT7];
  assign rd     = instr[`RV_RD];

  // unused source fields read as x0 so they never trigger a stall
  assign rs1_o = uses_rs1 ? instr[`RV_RS1] : 5'd0;
  assign rs2_o = uses_rs2 ? instr[`RV_RS2] : 5'd0;

  always_comb begin
    alu_op    = rv_isa_pkg::ALU_ADD;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    imm       = '0;
    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        case (funct3)
          3'b000: begin
            alu_op = (funct7 == 7'b0100000) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
          end
          3'b010:  alu_op = rv_isa_pkg::ALU_SLT;
          3'b100:  alu_op = rv_isa_pkg::ALU_XOR;
          3'b110:  alu_op = rv_isa_pkg::ALU_OR;
          3'b111:  alu_op = rv_isa_pkg::ALU_AND;
          default: alu_op = rv_isa_pkg::ALU_ADD;
        endcase
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        uses_rs1  = 1'b1;
        imm       = {{20{instr[31]}}, instr[31:20]};
      end
      rv_isa_pkg::OPC_LUI: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        alu_op    = rv_isa_pkg::ALU_PASS_B;
        imm       = {instr[31:12], 12'b0};
      end
      rv_isa_pkg::OPC_LOAD: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        use_imm   = 1'b1;
        uses_rs1  = 1'b1;
        imm       = {{20{instr[31]}}, instr[31:20]};
      end
      rv_isa_pkg::OPC_STORE: begin
        mem_write = 1'b1;
        use_imm   = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      rv_isa_pkg::OPC_BRANCH: begin
        branch   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        imm      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      rv_isa_pkg::OPC_JAL: begin
        jump      = 1'b1;
        reg_write = 1'b1;
        imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: ;
    endcase
  end

  // register file, x0 hardwired, same-cycle write bypass
  assign rs1_val = (rs1_o == 5'd0) ? '0 :
                   (wb_i.reg_write && wb_i.rd == rs1_o) ? wb_i.wdata : regs[rs1_o];
  assign rs2_val = (rs2_o == 5'd0) ? '0 :
                   (wb_i.reg_write && wb_i.rd == rs2_o) ? wb_i.wdata : regs[rs2_o];

  always_ff @(posedge clk) begin
    if (wb_i.reg_write && wb_i.rd != 5'd0) begin
      regs[wb_i.rd] <= wb_i.wdata;
    end
  end

  // bubble on stall, flush or an empty slot
  always_ff @(posedge clk) begin
    if (reset_i || hz_i.stall || hz_i.flush || !if_id_i.valid) begin
      id_ex_o.valid     <= 1'b0;
      id_ex_o.reg_write <= 1'b0;
      id_ex_o.mem_read  <= 1'b0;
      id_ex_o.mem_write <= 1'b0;
      id_ex_o.branch    <= 1'b0;
      id_ex_o.jump      <= 1'b0;
    end else begin
      id_ex_o.valid     <= 1'b1;
      id_ex_o.reg_write <= reg_write;
      id_ex_o.mem_read  <= mem_read;
      id_ex_o.mem_write <= mem_write;
      id_ex_o.branch    <= branch;
      id_ex_o.jump      <= jump;
    end
  end

  always_ff @(posedge clk) begin
    id_ex_o.pc        <= if_id_i.pc;
    id_ex_o.rs1_val   <= rs1_val;
    id_ex_o.rs2_val   <= rs2_val;
    id_ex_o.rs1       <= rs1_o;
    id_ex_o.rs2       <= rs2_o;
    id_ex_o.rd        <= rd;
    id_ex_o.imm       <= imm;
    id_ex_o.alu_op    <= alu_op;
    id_ex_o.use_imm   <= use_imm;
    id_ex_o.branch_ne <= funct3[0];
  end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`default_nettype none

`include "rv_defs.svh"

module fetch_stage (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic [`RV_XLEN-1:0]    imem_data_i,
  input  logic                   redirect_valid_i,
  input  logic [`RV_XLEN-1:0]    redirect_pc_i,
  input  pipe_pkg::hazard_ctrl_t hz_i,
  output logic [`RV_XLEN-1:0]    imem_addr_o,
  output pipe_pkg::if_id_t       if_id_o
);

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_d;

  assign imem_addr_o = pc_q;

  // redirect wins over a load-use hold
  always_comb begin
    if (redirect_valid_i) begin
      pc_d = redirect_pc_i;
    end else if (hz_i.stall) begin
      pc_d = pc_q;
    end else begin
      pc_d = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= `RV_BOOT_ADDR;
    end else begin
      pc_q <= pc_d;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || hz_i.flush) begin
      if_id_o.valid <= 1'b0;
    end else if (!hz_i.stall) begin
      if_id_o.valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (hz_i.flush) begin
      if_id_o.instr <= `RV_NOP;
    end else if (!hz_i.stall) begin
      if_id_o.pc    <= pc_q;
      if_id_o.instr <= imem_data_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/pipe_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package pipe_pkg;

  typedef enum logic [1:0] {
    FWD_NONE     = 2'd0,
    FWD_FROM_MEM = 2'd1,
    FWD_FROM_WB  = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     stall;
    logic     flush;
  } hazard_ctrl_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;
    logic                valid;
  } if_id_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] imm;
    rv_isa_pkg::alu_op_e alu_op;
    logic                use_imm;
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic                branch;
    logic                branch_ne;
    logic                jump;
    logic                valid;
  } id_ex_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] store_data;
    logic [4:0]          rd;
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic [`RV_XLEN-1:0] link_pc;
    logic                jump;
  } ex_mem_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] wdata;
    logic [4:0]          rd;
    logic                reg_write;
  } mem_wb_t;

  // data memory port as seen at the core boundary
  typedef struct packed {
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic                we;
  } dmem_req_t;

endpackage

`default_nettype wire

//--- verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // alu functions
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    // lui result, operand b straight through
    ALU_PASS_B = 3'd6
  } alu_op_e;

endpackage

`default_nettype wire

//--- verilog/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// machine width and register file size
`define RV_XLEN      32
`define RV_REGS      32

// reset pc
`define RV_BOOT_ADDR 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP       32'h0000_0013

// instruction field positions
`define RV_OPCODE    6:0
`define RV_RD        11:7
`define RV_FUNCT3    14:12
`define RV_RS1       19:15
`define RV_RS2       24:20
`define RV_FUNCT7    31:25

`endif
